// ==== Bender.yml ====
package:
  name: a7800_io

sources:
  - files:
      - source/cart_pkg.sv
      - source/io_pkg.sv
      - source/cart_header_decode.sv
      - source/console_port_map.sv
      - source/hsc_backup_ram.sv
      - source/backup_sequencer.sv
      - source/a7800_io_top.sv
  - target: simulation
    files:
      - sim/tb_a7800_io.sv

// ==== sim/tb_a7800_io.sv ====
// Testbench for the 7800 console glue
// Streams a 7800 and a 2600 image, walks the port-mapping table and the
// option modes, then runs a load and a save against a sector responder
module tb_a7800_io;
	timeunit 1ns;
	timeprecision 100ps;

	//==========================================================================
	// Run constants
	//==========================================================================
	localparam int HDR_LEN        = 128;
	localparam int BACKUP_SECTORS = 4;
	localparam int SECTOR_BYTES   = 512;
	localparam int RAM_BYTES      = BACKUP_SECTORS * SECTOR_BYTES;
	localparam int IMG1_LEN       = 256;
	localparam int IMG2_LEN       = 200;
	localparam int ACK_DELAY      = 3;
	localparam logic [31:0] RAND_SEED = 32'h8286;
	// Two images, two transfers, three full passes over the RAM, doubled
	localparam int TEST_CYCLES = IMG1_LEN + IMG2_LEN + 3 * RAM_BYTES + 200 +
		2 * BACKUP_SECTORS * (SECTOR_BYTES + 2 * ACK_DELAY);
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

	// One row of the port-mapping table
	typedef struct packed {
		logic [15:0] joy0;
		logic [15:0] joy1;
		logic [4:0]  sw;      // swap, diff_l, diff_r, bw, tia_en
		logic [7:0]  pb_out;
		logic [7:0]  exp_pa;
		logic [7:0]  exp_pb;
		logic [1:0]  exp_il;
		logic [3:0]  exp_id;
	} port_row_t;

	logic        clk_sys;
	logic        reset;
	logic        cart_download, image_is_2600, ioctl_wr;
	logic [24:0] ioctl_addr, cart_write_addr;
	logic [7:0]  ioctl_dout;
	logic        cart_is_7800, cart_loaded, tia_mode;
	logic [15:0] cart_flags;
	logic [31:0] cart_size;
	logic [15:0] joy0, joy1;
	logic        swap_joysticks, diff_left, diff_right, bw_mode, tia_en;
	logic [7:0]  pb_out, pa_in, pb_in;
	logic [1:0]  region_mode, hsc_mode, ilatch;
	logic [3:0]  idump;
	logic        pal, hsc_en;
	logic [10:0] hsc_addr;
	logic [7:0]  hsc_din, hsc_dout;
	logic        hsc_cs, rw;
	logic        img_mounted, img_readonly, img_present, osd_status;
	logic [31:0] sd_lba;
	logic        sd_rd, sd_wr, sd_ack, sd_buff_wr;
	logic [8:0]  sd_buff_addr;
	logic [7:0]  sd_buff_dout, sd_buff_din;
	logic        backup_busy, save_pending, backup_enabled, activity_led;

	// Scoreboard state
	int          error_count;
	int          check_count;
	int          cycle_count;
	int          seed_dummy;
	logic [15:0] exp_flags;
	logic [7:0]  img [0:IMG1_LEN-1];
	logic [7:0]  load_data [0:RAM_BYTES-1];
	logic [7:0]  save_data [0:RAM_BYTES-1];
	logic [7:0]  cap_data [0:RAM_BYTES-1];
	int          req_lba[$];
	logic        req_wr[$];
	port_row_t   port_rows[$];

	a7800_io_top #(.HEADER_LEN(HDR_LEN), .BACKUP_SECTORS(BACKUP_SECTORS)) UUT (.*);

	always #10 clk_sys = ~clk_sys;

	// Watchdog
	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Checks failed");
			$finish;
		end
	end

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("MISMATCH at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	//==========================================================================
	// SD responder model
	//==========================================================================
	// One sector, read fills the buffer and write captures it
	task automatic serve_sector();
		int   base;
		logic is_wr;
		is_wr = sd_wr;
		base  = int'(sd_lba[1:0]) * SECTOR_BYTES;
		req_lba.push_back(int'(sd_lba));
		req_wr.push_back(is_wr);
		repeat (ACK_DELAY) @(posedge clk_sys);
		#2;
		sd_ack = 1'b1;
		for (int i = 0; i <= SECTOR_BYTES; i++) begin
			@(posedge clk_sys);
			#2;
			if (is_wr) begin
				// Buffer read data lags the address by a clock
				if (i > 0)
					cap_data[base + i - 1] = sd_buff_din;
				if (i < SECTOR_BYTES)
					sd_buff_addr = 9'(i);
			end else if (i < SECTOR_BYTES) begin
				sd_buff_addr = 9'(i);
				sd_buff_dout = load_data[base + i];
				sd_buff_wr   = 1'b1;
			end else begin
				sd_buff_wr = 1'b0;
			end
		end
		// Falling ack completes the sector
		sd_ack = 1'b0;
	endtask

	initial begin : sd_responder
		forever begin
			@(posedge clk_sys);
			#2;
			if (sd_rd === 1'b1 || sd_wr === 1'b1)
				serve_sector();
		end
	end

	//==========================================================================
	// Stimulus tasks
	//==========================================================================
	// Streams img[0..len-1], checks the stripped address on 7800 images
	task automatic stream_image(input int len, input logic is_2600);
		@(posedge clk_sys);
		#2;
		cart_download = 1'b1;
		image_is_2600 = is_2600;
		for (int i = 0; i < len; i++) begin
			@(posedge clk_sys);
			#2;
			ioctl_wr   = 1'b1;
			ioctl_addr = 25'(i);
			ioctl_dout = img[i];
			if (!is_2600 && i >= HDR_LEN) begin
				#6;
				check_value($sformatf("cart_write_addr at %0d", i), cart_write_addr, i - HDR_LEN);
			end
		end
		@(posedge clk_sys);
		#2;
		ioctl_wr      = 1'b0;
		cart_download = 1'b0;
		// Let the signature compare and size settle
		repeat (2) @(posedge clk_sys);
		#2;
	endtask

	task automatic apply_port_table();
		port_row_t row;
		for (int r = 0; r < port_rows.size(); r++) begin
			row = port_rows[r];
			@(posedge clk_sys);
			#2;
			joy0 = row.joy0;
			joy1 = row.joy1;
			{swap_joysticks, diff_left, diff_right, bw_mode, tia_en} = row.sw;
			pb_out = row.pb_out;
			#8;
			check_value($sformatf("row %0d pa_in", r), pa_in, row.exp_pa);
			check_value($sformatf("row %0d pb_in", r), pb_in, row.exp_pb);
			check_value($sformatf("row %0d ilatch", r), ilatch, row.exp_il);
			check_value($sformatf("row %0d idump", r), idump, row.exp_id);
		end
	endtask

	// All region and high-score modes against the streamed header bytes
	task automatic sweep_options(input logic hdr_region, input logic [7:0] save_b,
		input logic [7:0] xm_b);
		logic exp_pal;
		logic exp_hsc;
		for (int rm = 0; rm < 3; rm++) begin
			for (int hm = 0; hm < 4; hm++) begin
				@(posedge clk_sys);
				#2;
				region_mode = 2'(rm);
				hsc_mode    = 2'(hm);
				exp_pal = (rm == 0) ? hdr_region : (rm == 2);
				exp_hsc = (hm == 0) ? ((save_b != 8'd0) || xm_b[0]) : (hm != 2);
				#8;
				check_value($sformatf("pal, region %0d", rm), pal, exp_pal);
				check_value($sformatf("hsc_en, mode %0d", hm), hsc_en, exp_hsc);
			end
		end
	endtask

	task automatic wait_transfer_done();
		@(posedge clk_sys);
		#1;
		while (!backup_busy) begin
			@(posedge clk_sys);
			#1;
		end
		while (backup_busy) begin
			@(posedge clk_sys);
			#1;
		end
	endtask

	task automatic check_requests(input logic exp_wr);
		check_value("request count", req_lba.size(), BACKUP_SECTORS);
		for (int k = 0; k < req_lba.size(); k++) begin
			check_value($sformatf("request %0d lba", k), req_lba[k], k);
			check_value($sformatf("request %0d is write", k), req_wr[k], exp_wr);
		end
	endtask

	// Pipelined console reads, data one clock behind the address
	task automatic read_back_ram();
		for (int i = 0; i <= RAM_BYTES; i++) begin
			@(posedge clk_sys);
			#2;
			if (i > 0)
				check_value($sformatf("RAM byte %0d", i - 1), hsc_dout, load_data[i - 1]);
			if (i < RAM_BYTES) begin
				hsc_cs   = 1'b1;
				rw       = 1'b1;
				hsc_addr = 11'(i);
			end
		end
		hsc_cs = 1'b0;
	endtask

	task automatic write_console_ram();
		for (int i = 0; i < RAM_BYTES; i++) begin
			@(posedge clk_sys);
			#2;
			hsc_cs   = 1'b1;
			rw       = 1'b0;
			hsc_addr = 11'(i);
			hsc_din  = save_data[i];
		end
		@(posedge clk_sys);
		#2;
		hsc_cs = 1'b0;
		rw     = 1'b1;
	endtask

	//==========================================================================
	// Main sequence
	//==========================================================================
	initial begin
		clk_sys = 1'b0;
		reset = 1'b1;
		{cart_download, image_is_2600, ioctl_wr} = '0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		{joy0, joy1} = '0;
		{swap_joysticks, diff_left, diff_right, bw_mode, tia_en} = '0;
		pb_out = 8'hff;
		region_mode = 2'd0;
		hsc_mode = 2'd0;
		{hsc_addr, hsc_din, hsc_cs} = '0;
		rw = 1'b1;
		{img_mounted, img_readonly, img_present, osd_status} = '0;
		{sd_ack, sd_buff_wr, sd_buff_addr, sd_buff_dout} = '0;
		error_count = 0;
		check_count = 0;
		cycle_count = 0;
		seed_dummy = $urandom(RAND_SEED);

		// joy0, joy1, swap/dl/dr/bw/tia, pb_out, then pa, pb, ilatch, idump
		port_rows.push_back({16'h0000, 16'h0000, 5'b00000, 8'hff, 8'hff, 8'hff, 2'b11, 4'b0000});
		port_rows.push_back({16'h0019, 16'h0006, 5'b00000, 8'hff, 8'h69, 8'hff, 2'b10, 4'b0010});
		port_rows.push_back({16'h0019, 16'h0006, 5'b10000, 8'hff, 8'h96, 8'hff, 2'b01, 4'b1000});
		port_rows.push_back({16'h0100, 16'h00c0, 5'b01010, 8'hff, 8'hff, 8'ha4, 2'b11, 4'b0000});
		port_rows.push_back({16'h0020, 16'h0030, 5'b00100, 8'h00, 8'hff, 8'h7f, 2'b11, 4'b1101});
		port_rows.push_back({16'h0020, 16'h0030, 5'b00001, 8'h00, 8'hff, 8'hff, 2'b00, 4'b1101});
		port_rows.push_back({16'h0010, 16'h0010, 5'b00000, 8'h04, 8'hff, 8'hff, 2'b10, 4'b1010});

		repeat (3) @(posedge clk_sys);
		#2;
		reset = 1'b0;
		check_value("sd_rd after reset", sd_rd, 1'b0);
		check_value("sd_wr after reset", sd_wr, 1'b0);
		check_value("backup_busy after reset", backup_busy, 1'b0);
		check_value("save_pending after reset", save_pending, 1'b0);
		check_value("backup_enabled after reset", backup_enabled, 1'b0);
		check_value("cart_loaded after reset", cart_loaded, 1'b0);

		apply_port_table();

		// 7800 image with signature, region 1 and a high-score save byte
		exp_flags = 16'($urandom);
		for (int i = 0; i < IMG1_LEN; i++)
			img[i] = 8'($urandom);
		{img[1], img[2], img[3], img[4], img[5]} = 40'h41_54_41_52_49;
		img[53] = exp_flags[15:8];
		img[54] = exp_flags[7:0];
		img[57] = 8'h01;
		img[58] = 8'h01;
		img[63] = 8'h00;
		stream_image(IMG1_LEN, 1'b0);
		check_value("7800 cart_is_7800", cart_is_7800, 1'b1);
		check_value("7800 cart_flags", cart_flags, exp_flags);
		check_value("7800 cart_loaded", cart_loaded, 1'b1);
		check_value("7800 cart_size", cart_size, IMG1_LEN - HDR_LEN);
		check_value("7800 tia_mode", tia_mode, 1'b0);
		sweep_options(1'b1, 8'h01, 8'h00);

		// 2600 image, mounted save image so a load follows
		// XM byte set alone so auto mode rests on the expansion bit
		for (int i = 0; i < RAM_BYTES; i++)
			load_data[i] = 8'($urandom);
		for (int i = 0; i < IMG2_LEN; i++)
			img[i] = 8'($urandom);
		img[1]  = 8'h00;
		img[58] = 8'h00;
		img[63] = 8'h01;
		img_mounted = 1'b1;
		img_present = 1'b1;
		stream_image(IMG2_LEN, 1'b1);
		check_value("2600 cart_is_7800", cart_is_7800, 1'b0);
		check_value("2600 cart_flags", cart_flags, 16'h0000);
		check_value("2600 tia_mode", tia_mode, 1'b1);
		check_value("2600 cart_size", cart_size, IMG2_LEN);
		check_value("backup_enabled", backup_enabled, 1'b1);
		sweep_options(1'b0, 8'h00, 8'h01);

		// Load, four reads then the RAM holds the responder bytes
		wait_transfer_done();
		check_requests(1'b0);
		read_back_ram();

		// Save, console writes mark a pending save until the OSD opens
		for (int i = 0; i < RAM_BYTES; i++)
			save_data[i] = 8'($urandom);
		req_lba.delete();
		req_wr.delete();
		write_console_ram();
		check_value("save_pending after writes", save_pending, 1'b1);
		check_value("activity_led with pending save", activity_led, 1'b1);
		osd_status = 1'b1;
		wait_transfer_done();
		check_requests(1'b1);
		for (int i = 0; i < RAM_BYTES; i++)
			check_value($sformatf("saved byte %0d", i), cap_data[i], save_data[i]);
		check_value("save_pending after save", save_pending, 1'b0);
		osd_status = 1'b0;

		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== source/a7800_io_top.sv ====
// Atari 7800 console glue
// Cartridge header decode, gamepad and switch mapping, high-score RAM
// and its sector backup, all on the system clock
module a7800_io_top #(
	parameter int HEADER_LEN     = cart_pkg::HDR_LEN_DEFAULT,
	parameter int BACKUP_SECTORS = 4
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	// Image download
	input  logic                  cart_download,
	input  logic                  image_is_2600,
	input  logic                  ioctl_wr,
	input  cart_pkg::ioctl_addr_t ioctl_addr,
	input  logic [7:0]            ioctl_dout,
	output logic                  cart_is_7800,
	output cart_pkg::cart_flags_t cart_flags,
	output cart_pkg::cart_size_t  cart_size,
	output cart_pkg::ioctl_addr_t cart_write_addr,
	output logic                  cart_loaded,
	output logic                  tia_mode,
	// Controls and options
	input  io_pkg::joy_t          joy0,
	input  io_pkg::joy_t          joy1,
	input  logic                  swap_joysticks,
	input  logic                  diff_left,
	input  logic                  diff_right,
	input  logic                  bw_mode,
	input  logic                  tia_en,
	input  logic [7:0]            pb_out,
	input  io_pkg::region_mode_t  region_mode,
	input  io_pkg::hsc_mode_t     hsc_mode,
	output logic [7:0]            pa_in,
	output logic [7:0]            pb_in,
	output logic [1:0]            ilatch,
	output logic [3:0]            idump,
	output logic                  pal,
	output logic                  hsc_en,
	// Console side of the high-score RAM
	input  logic [10:0]           hsc_addr,
	input  logic [7:0]            hsc_din,
	input  logic                  hsc_cs,
	input  logic                  rw,
	output logic [7:0]            hsc_dout,
	// Save image and sector buffer
	input  logic                  img_mounted,
	input  logic                  img_readonly,
	input  logic                  img_present,
	input  logic                  osd_status,
	output logic [31:0]           sd_lba,
	output logic                  sd_rd,
	output logic                  sd_wr,
	input  logic                  sd_ack,
	input  logic [8:0]            sd_buff_addr,
	input  logic [7:0]            sd_buff_dout,
	input  logic                  sd_buff_wr,
	output logic [7:0]            sd_buff_din,
	output logic                  backup_busy,
	output logic                  save_pending,
	output logic                  backup_enabled,
	output logic                  activity_led
);
	import cart_pkg::*;

	logic       cart_region;
	logic [7:0] cart_save;
	logic [7:0] cart_xm;
	logic       hsc_we;

	// Console write, rw is low for a write
	assign hsc_we       = hsc_cs & ~rw;
	assign activity_led = cart_download | backup_busy | save_pending;

	cart_header_decode #(.HEADER_LEN(HEADER_LEN)) u_decode (
		.clk_sys, .reset, .cart_download, .image_is_2600, .ioctl_wr, .ioctl_addr,
		.ioctl_dout, .cart_is_7800, .cart_flags, .cart_region, .cart_save, .cart_xm,
		.cart_size, .cart_write_addr, .cart_loaded, .tia_mode
	);

	console_port_map u_port_map (
		.joy0, .joy1, .swap_joysticks, .diff_left, .diff_right, .bw_mode, .tia_en,
		.pb_out, .region_mode, .hsc_mode, .cart_region, .cart_save, .cart_xm,
		.pa_in, .pb_in, .ilatch, .idump, .pal, .hsc_en
	);

	// Buffer writes only count while the host acknowledges
	hsc_backup_ram #(.BACKUP_SECTORS(BACKUP_SECTORS)) u_ram (
		.clk_sys, .hsc_addr, .hsc_din, .hsc_we,
		.sd_lba_sel  (sd_lba[SECTOR_SEL_BITS-1:0]),
		.sd_buff_addr,
		.sd_buff_dout,
		.sd_buff_we  (sd_buff_wr & sd_ack),
		.hsc_dout, .sd_buff_din
	);

	backup_sequencer #(.BACKUP_SECTORS(BACKUP_SECTORS)) u_seq (
		.clk_sys, .reset, .cart_download, .img_mounted, .img_readonly, .img_present,
		.osd_status, .hsc_we, .sd_ack, .sd_lba, .sd_rd, .sd_wr, .backup_busy,
		.save_pending, .backup_enabled
	);

endmodule

// ==== source/backup_sequencer.sv ====
// High-score backup sequencer
// Arms backup when a writable save image is mounted with the cartridge,
// flags console writes as a pending save and moves the RAM to or from
// the save image one sector at a time
module backup_sequencer #(
	parameter int BACKUP_SECTORS = 4
) (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        cart_download,
	input  logic        img_mounted,
	input  logic        img_readonly,
	input  logic        img_present,
	input  logic        osd_status,
	input  logic        hsc_we,
	input  logic        sd_ack,
	output logic [31:0] sd_lba,
	output logic        sd_rd,
	output logic        sd_wr,
	output logic        backup_busy,
	output logic        save_pending,
	output logic        backup_enabled
);
	localparam logic [31:0] LAST_LBA = 32'(BACKUP_SECTORS - 1);

	logic dl_q;
	logic ack_q;
	logic save_req_q;
	logic loading;
	logic save_req;
	logic dl_rise;
	logic dl_fall;
	logic ack_rise;
	logic ack_fall;

	assign dl_rise  = cart_download & ~dl_q;
	assign dl_fall  = ~cart_download & dl_q;
	assign ack_rise = sd_ack & ~ack_q;
	assign ack_fall = ~sd_ack & ack_q;
	// Save goes out when the OSD opens with unsaved scores
	assign save_req = save_pending & osd_status & backup_enabled;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_q       <= 1'b0;
			ack_q      <= 1'b0;
			save_req_q <= 1'b0;
		end else begin
			dl_q       <= cart_download;
			ack_q      <= sd_ack;
			save_req_q <= save_req;
		end
	end

	//==========================================================================
	// Enable and pending save
	//==========================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			backup_enabled <= 1'b0;
			save_pending   <= 1'b0;
		end else begin
			// Save image is mounted while the cartridge streams in
			if (dl_rise)
				backup_enabled <= 1'b0;
			if (cart_download && img_mounted && !img_readonly)
				backup_enabled <= 1'b1;
			if (backup_enabled && !osd_status && hsc_we)
				save_pending <= 1'b1;
			else if (backup_busy)
				save_pending <= 1'b0;
		end
	end

	//==========================================================================
	// Sector transfers
	//==========================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sd_lba      <= '0;
			sd_rd       <= 1'b0;
			sd_wr       <= 1'b0;
			backup_busy <= 1'b0;
			loading     <= 1'b0;
		end else begin
			// Request drops once the host takes it
			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end
			if (!backup_busy) begin
				if (dl_fall && img_present && backup_enabled) begin
					backup_busy <= 1'b1;
					loading     <= 1'b1;
					sd_lba      <= '0;
					sd_rd       <= 1'b1;
				end else if (save_req && !save_req_q) begin
					backup_busy <= 1'b1;
					loading     <= 1'b0;
					sd_lba      <= '0;
					sd_wr       <= 1'b1;
				end
			end else if (ack_fall) begin
				// Sector done, next one or finish
				if (sd_lba == LAST_LBA) begin
					backup_busy <= 1'b0;
					loading     <= 1'b0;
				end else begin
					sd_lba <= sd_lba + 32'd1;
					sd_rd  <= loading;
					sd_wr  <= ~loading;
				end
			end
		end
	end

endmodule

// ==== source/cart_header_decode.sv ====
// Cartridge header decoder
// Watches the image stream and picks the header fields out of it,
// tracks the ROM size and strips the 7800 header off the write address
module cart_header_decode #(
	parameter int HEADER_LEN = cart_pkg::HDR_LEN_DEFAULT
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  cart_download,
	input  logic                  image_is_2600,
	input  logic                  ioctl_wr,
	input  cart_pkg::ioctl_addr_t ioctl_addr,
	input  logic [7:0]            ioctl_dout,
	output logic                  cart_is_7800,
	output cart_pkg::cart_flags_t cart_flags,
	output logic                  cart_region,
	output logic [7:0]            cart_save,
	output logic [7:0]            cart_xm,
	output cart_pkg::cart_size_t  cart_size,
	output cart_pkg::ioctl_addr_t cart_write_addr,
	output logic                  cart_loaded,
	output logic                  tia_mode
);
	import cart_pkg::*;

	localparam int          SIG_BYTES = $bits(HDR_SIGNATURE) / 8;
	localparam ioctl_addr_t HDR_ADDR  = ioctl_addr_t'(HEADER_LEN);
	localparam cart_size_t  HDR_SIZE  = cart_size_t'(HEADER_LEN);

	logic [$bits(HDR_SIGNATURE)-1:0] sig_q;
	cart_flags_t                     flags_q;
	logic                            region_q;
	logic                            byte_strobe;
	logic                            in_sig;

	// Byte of the cartridge image arriving this cycle
	assign byte_strobe = cart_download & ioctl_wr;

	// Offsets 1..5 hold the signature
	assign in_sig = (ioctl_addr >= ioctl_addr_t'(HDR_SIG_FIRST)) &&
		(ioctl_addr < ioctl_addr_t'(HDR_SIG_FIRST + SIG_BYTES));

	//==========================================================================
	// Header capture
	//==========================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sig_q        <= '0;
			flags_q      <= '0;
			region_q     <= 1'b0;
			cart_save    <= 8'd0;
			cart_xm      <= 8'd0;
			cart_size    <= '0;
			cart_loaded  <= 1'b0;
			tia_mode     <= 1'b0;
			cart_is_7800 <= 1'b0;
		end else begin
			// Signature compare lags the signature by one clock
			cart_is_7800 <= (sig_q == HDR_SIGNATURE);
			if (cart_download)
				tia_mode <= image_is_2600;
			if (byte_strobe) begin
				// Last address plus one, header excluded for 7800 images
				cart_size <= cart_size_t'(ioctl_addr) + 32'd1 -
					(cart_is_7800 ? HDR_SIZE : '0);
				// Signature shifts in MSB first
				if (in_sig)
					sig_q <= {sig_q[$bits(HDR_SIGNATURE)-9:0], ioctl_dout};
				case (ioctl_addr)
					HDR_FLAGS_HI: flags_q[15:8] <= ioctl_dout;
					HDR_FLAGS_LO: flags_q[7:0] <= ioctl_dout;
					// 0 NTSC, 1 PAL
					HDR_REGION:   region_q <= ioctl_dout[0];
					// 0 none, 1 high-score cart, 2 SaveKey
					HDR_SAVE:     cart_save <= ioctl_dout;
					// Bit 0 marks an XM expansion
					HDR_XM:       cart_xm <= ioctl_dout;
					HDR_LOADED:   cart_loaded <= 1'b1;
					default:      ;
				endcase
			end
		end
	end

	// Header fields only mean something on a 7800 image
	assign cart_flags  = cart_is_7800 ? flags_q : '0;
	assign cart_region = cart_is_7800 & region_q;

	// ROM write address with the header stripped
	assign cart_write_addr = (cart_is_7800 && (ioctl_addr >= HDR_ADDR)) ?
		ioctl_addr - HDR_ADDR : ioctl_addr;

endmodule

// ==== source/cart_pkg.sv ====
// Cartridge package
// Layout of the 7800 cartridge image header and the geometry of the
// high-score backup file
package cart_pkg;

	//==========================================================================
	// Types
	//==========================================================================

	// Byte address of the download stream
	typedef logic [24:0] ioctl_addr_t;

	// Mapper flags from header bytes 53 and 54
	typedef logic [15:0] cart_flags_t;

	// Cartridge byte count
	typedef logic [31:0] cart_size_t;

	//==========================================================================
	// Header layout
	//==========================================================================

	// Signature, five ASCII bytes from offset 1
	localparam logic [39:0] HDR_SIGNATURE = "ATARI";
	localparam int HDR_SIG_FIRST = 1;

	// Single-byte fields
	localparam int HDR_FLAGS_HI = 53;
	localparam int HDR_FLAGS_LO = 54;
	localparam int HDR_REGION   = 57;
	localparam int HDR_SAVE     = 58;
	localparam int HDR_XM       = 63;
	// Image counts as loaded once the stream passes this byte
	localparam int HDR_LOADED   = 64;

	// Header bytes that precede the ROM data
	localparam int HDR_LEN_DEFAULT = 128;

	// Backup file is made of 512-byte sectors, up to four of them
	localparam int SECTOR_ADDR_BITS = 9;
	localparam int SECTOR_SEL_BITS  = 2;

endpackage

// ==== source/console_port_map.sv ====
// Console port mapper
// Turns the host gamepads and front-panel switches into RIOT port A/B
// and TIA latch/dump inputs, and resolves the region and high-score
// options against the cartridge header
module console_port_map (
	input  io_pkg::joy_t         joy0,
	input  io_pkg::joy_t         joy1,
	input  logic                 swap_joysticks,
	input  logic                 diff_left,
	input  logic                 diff_right,
	input  logic                 bw_mode,
	input  logic                 tia_en,
	input  logic [7:0]           pb_out,
	input  io_pkg::region_mode_t region_mode,
	input  io_pkg::hsc_mode_t    hsc_mode,
	input  logic                 cart_region,
	input  logic [7:0]           cart_save,
	input  logic [7:0]           cart_xm,
	output logic [7:0]           pa_in,
	output logic [7:0]           pb_in,
	output logic [1:0]           ilatch,
	output logic [3:0]           idump,
	output logic                 pal,
	output logic                 hsc_en
);
	import io_pkg::*;

	joy_t joy_a;
	joy_t joy_b;
	logic two_btn_a;
	logic two_btn_b;

	// Player 1 and player 2 after the optional swap
	assign joy_a = swap_joysticks ? joy1 : joy0;
	assign joy_b = swap_joysticks ? joy0 : joy1;

	// Directions, active low, P1 in the high nibble
	assign pa_in = {~joy_a[JOY_RIGHT], ~joy_a[JOY_LEFT], ~joy_a[JOY_DOWN], ~joy_a[JOY_UP],
		~joy_b[JOY_RIGHT], ~joy_b[JOY_LEFT], ~joy_b[JOY_DOWN], ~joy_b[JOY_UP]};

	// Console switches, unused bits pulled high
	always_comb begin
		pb_in = 8'hff;
		pb_in[PB_RESET]  = ~(joy_a[JOY_START] | joy_b[JOY_START]);
		pb_in[PB_SELECT] = ~(joy_a[JOY_SELECT] | joy_b[JOY_SELECT]);
		pb_in[PB_PAUSE]  = ~(joy_a[JOY_PAUSE] | joy_b[JOY_PAUSE]);
		pb_in[PB_BW]     = ~bw_mode;
		pb_in[PB_DIFF_L] = ~diff_left;
		pb_in[PB_DIFF_R] = ~diff_right;
	end

	// Two-button mode holds the shared fire pin high
	assign two_btn_a = ~pb_out[PB_TWO_BTN_A] & ~tia_en;
	assign two_btn_b = ~pb_out[PB_TWO_BTN_B] & ~tia_en;
	assign ilatch[0] = two_btn_a | ~(joy_a[JOY_FIRE1] | joy_a[JOY_FIRE2]);
	assign ilatch[1] = two_btn_b | ~(joy_b[JOY_FIRE1] | joy_b[JOY_FIRE2]);

	// Paddle inputs see the raw buttons in either mode
	assign idump = {joy_b[JOY_FIRE1], joy_b[JOY_FIRE2], joy_a[JOY_FIRE1], joy_a[JOY_FIRE2]};

	// Region, auto follows the header
	always_comb begin
		case (region_mode)
			REGION_AUTO: pal = cart_region;
			REGION_NTSC: pal = 1'b0;
			REGION_PAL:  pal = 1'b1;
			default:     pal = cart_region;
		endcase
	end

	// High-score cart, auto when the header asks for saves or XM
	always_comb begin
		case (hsc_mode)
			HSC_AUTO:           hsc_en = (|cart_save) | cart_xm[0];
			HSC_ON, HSC_ON_ALT: hsc_en = 1'b1;
			HSC_OFF:            hsc_en = 1'b0;
			default:            hsc_en = 1'b0;
		endcase
	end

endmodule

// ==== source/hsc_backup_ram.sv ====
// High-score cartridge RAM
// True dual-port byte RAM, console on port A and the sector buffer on
// port B, registered reads on both sides
module hsc_backup_ram #(
	parameter int BACKUP_SECTORS = 4
) (
	input  logic                                  clk_sys,
	input  logic [10:0]                           hsc_addr,
	input  logic [7:0]                            hsc_din,
	input  logic                                  hsc_we,
	input  logic [cart_pkg::SECTOR_SEL_BITS-1:0]  sd_lba_sel,
	input  logic [cart_pkg::SECTOR_ADDR_BITS-1:0] sd_buff_addr,
	input  logic [7:0]                            sd_buff_dout,
	input  logic                                  sd_buff_we,
	output logic [7:0]                            hsc_dout,
	output logic [7:0]                            sd_buff_din
);
	import cart_pkg::*;

	// One sector of bytes per backup sector
	localparam int DEPTH = BACKUP_SECTORS << SECTOR_ADDR_BITS;
	localparam int AW    = $clog2(DEPTH);

	logic [7:0]    mem [DEPTH];
	logic [10:0]   sd_addr;

	// Sector select on top of the buffer offset
	assign sd_addr = {sd_lba_sel, sd_buff_addr};

	// Console side
	always @(posedge clk_sys) begin
		if (hsc_we)
			mem[hsc_addr[AW-1:0]] <= hsc_din;
		hsc_dout <= mem[hsc_addr[AW-1:0]];
	end

	// Sector buffer side
	always @(posedge clk_sys) begin
		if (sd_buff_we)
			mem[sd_addr[AW-1:0]] <= sd_buff_dout;
		sd_buff_din <= mem[sd_addr[AW-1:0]];
	end

endmodule

// ==== source/io_pkg.sv ====
// Console input package
// Gamepad button positions, RIOT port B switch positions and the
// encodings of the region and high-score options
package io_pkg;

	// Host gamepad word, one bit per button, active high
	typedef logic [15:0] joy_t;

	//==========================================================================
	// Gamepad bits
	//==========================================================================
	localparam int JOY_RIGHT  = 0;
	localparam int JOY_LEFT   = 1;
	localparam int JOY_DOWN   = 2;
	localparam int JOY_UP     = 3;
	localparam int JOY_FIRE1  = 4;
	localparam int JOY_FIRE2  = 5;
	localparam int JOY_PAUSE  = 6;
	localparam int JOY_SELECT = 7;
	localparam int JOY_START  = 8;

	//==========================================================================
	// RIOT port B
	//==========================================================================
	// Inputs, all active low
	localparam int PB_RESET  = 0;
	localparam int PB_SELECT = 1;
	localparam int PB_PAUSE  = 3;
	localparam int PB_BW     = 4;
	localparam int PB_DIFF_L = 6;
	localparam int PB_DIFF_R = 7;
	// Outputs, low selects two-button mode per player
	localparam int PB_TWO_BTN_A = 2;
	localparam int PB_TWO_BTN_B = 4;

	// Region option
	typedef logic [1:0] region_mode_t;
	localparam region_mode_t REGION_AUTO = 2'd0;
	localparam region_mode_t REGION_NTSC = 2'd1;
	localparam region_mode_t REGION_PAL  = 2'd2;

	// High-score cart option, code 3 also means on
	typedef logic [1:0] hsc_mode_t;
	localparam hsc_mode_t HSC_AUTO   = 2'd0;
	localparam hsc_mode_t HSC_ON     = 2'd1;
	localparam hsc_mode_t HSC_OFF    = 2'd2;
	localparam hsc_mode_t HSC_ON_ALT = 2'd3;

endpackage

// ==== sources.f ====
source/cart_pkg.sv
source/io_pkg.sv
source/cart_header_decode.sv
source/console_port_map.sv
source/hsc_backup_ram.sv
source/backup_sequencer.sv
source/a7800_io_top.sv
sim/tb_a7800_io.sv
